/* design/lane_alu.sv */
`timescale 1ns/1ps

module lane_alu import lane_data_pkg::*; import lane_op_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Request channel
  input  logic    alu_req_valid_i,
  output logic    alu_req_ready_o,
  input  alu_op_e alu_op_i,
  input  ew_e     alu_ew_i,
  input  elen_t   alu_a_i,
  input  elen_t   alu_b_i,
  input  strb_t   alu_be_i,
  input  vid_t    alu_id_i,
  input  waddr_t  alu_addr_i,
  // Result towards the write-back arbiter
  output logic    result_req_o,
  output vid_t    result_id_o,
  output waddr_t  result_addr_o,
  output elen_t   result_wdata_o,
  output strb_t   result_be_o,
  input  logic    result_gnt_i
);

  localparam int unsigned NrBytes = $bits(strb_t);

  ////////////////////////////////////////////////////////////////////////////
  // SIMD adder
  ////////////////////////////////////////////////////////////////////////////

  logic       is_sub;
  elen_t      b_op;
  strb_t      elem_start;
  logic       carry;
  logic [8:0] byte_sum;
  elen_t      sum;
  elen_t      alu_result;

  // Subtract as a + ~b + 1, the +1 injected at each element start
  assign is_sub = (alu_op_i == SUB);
  assign b_op   = is_sub ? ~alu_b_i : alu_b_i;

  // Bytes where a new element begins
  always_comb begin
    unique case (alu_ew_i)
      EW8:     elem_start = 8'hff;
      EW16:    elem_start = 8'h55;
      EW32:    elem_start = 8'h11;
      default: elem_start = 8'h01;
    endcase
  end

  // Byte-wise ripple, carry chain cut at element boundaries
  always_comb begin
    carry    = 1'b0;
    byte_sum = '0;
    sum      = '0;
    for (int i = 0; i < NrBytes; i++) begin
      if (elem_start[i]) begin
        carry = is_sub;
      end
      byte_sum = {1'b0, alu_a_i[8*i +: 8]} + {1'b0, b_op[8*i +: 8]} + {8'b0, carry};
      sum[8*i +: 8] = byte_sum[7:0];
      carry = byte_sum[8];
    end
  end

  always_comb begin
    unique case (alu_op_i)
      ADD, SUB: alu_result = sum;
      AND:      alu_result = alu_a_i & alu_b_i;
      OR:       alu_result = alu_a_i | alu_b_i;
      XOR:      alu_result = alu_a_i ^ alu_b_i;
      default:  alu_result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  logic   result_req_q;
  vid_t   result_id_q;
  waddr_t result_addr_q;
  elen_t  result_wdata_q;
  strb_t  result_be_q;
  logic   accept;

  // Free slot, or the held result leaves this cycle
  assign alu_req_ready_o = ~result_req_q | result_gnt_i;
  assign accept          = alu_req_valid_i & alu_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_req_q <= 1'b0;
    end else if (accept) begin
      result_req_q <= 1'b1;
    end else if (result_gnt_i) begin
      result_req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      result_id_q    <= alu_id_i;
      result_addr_q  <= alu_addr_i;
      result_wdata_q <= alu_result;
      result_be_q    <= alu_be_i;
    end
  end

  assign result_req_o   = result_req_q;
  assign result_id_o    = result_id_q;
  assign result_addr_o  = result_addr_q;
  assign result_wdata_o = result_wdata_q;
  assign result_be_o    = result_be_q;

endmodule : lane_alu

/* design/lane_cfg.svh */
`ifndef LANE_CFG_SVH
`define LANE_CFG_SVH

// Datapath width of the lane, one element per beat
`define LANE_ELEN 64

// Request tag carried along with every result
`define LANE_TAG_W 4

// Destination address of a result
`define LANE_ADDR_W 6

// Register stages in the multiplier
// Also the number of products that can be in flight
`define LANE_MUL_STAGES 3

`endif

/* design/lane_data_pkg.sv */
`include "lane_cfg.svh"

package lane_data_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Payload types shared by the units and the write-back port
  ////////////////////////////////////////////////////////////////////////////

  // One element, as wide as the datapath
  typedef logic [`LANE_ELEN-1:0] elen_t;

  // One enable per byte of an element
  typedef logic [`LANE_ELEN/8-1:0] strb_t;

  // Tag of a request, echoed with its result
  typedef logic [`LANE_TAG_W-1:0] vid_t;

  // Where the result gets written
  typedef logic [`LANE_ADDR_W-1:0] waddr_t;

endpackage : lane_data_pkg

/* design/lane_mul.sv */
`timescale 1ns/1ps
`include "lane_cfg.svh"

module lane_mul import lane_data_pkg::*; import lane_op_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Request channel
  input  logic    mul_req_valid_i,
  output logic    mul_req_ready_o,
  input  mul_op_e mul_op_i,
  input  elen_t   mul_a_i,
  input  elen_t   mul_b_i,
  input  strb_t   mul_be_i,
  input  vid_t    mul_id_i,
  input  waddr_t  mul_addr_i,
  // Result towards the write-back arbiter
  output logic    result_req_o,
  output vid_t    result_id_o,
  output waddr_t  result_addr_o,
  output elen_t   result_wdata_o,
  output strb_t   result_be_o,
  input  logic    result_gnt_i
);

  localparam int unsigned NrStages = `LANE_MUL_STAGES;
  localparam int unsigned ElemW    = $bits(elen_t);
  localparam int unsigned ProdW    = 2 * ElemW;

  ////////////////////////////////////////////////////////////////////////////
  // Product
  ////////////////////////////////////////////////////////////////////////////

  // Full unsigned product, retimed across the stages below
  logic [ProdW-1:0] product;

  assign product = ProdW'(mul_a_i) * ProdW'(mul_b_i);

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////////////////////

  logic [NrStages-1:0] valid_q;
  logic [ProdW-1:0]    prod_q [NrStages];
  mul_op_e             op_q   [NrStages];
  vid_t                id_q   [NrStages];
  waddr_t              addr_q [NrStages];
  strb_t               be_q   [NrStages];

  logic advance;
  logic accept;

  // Whole pipe moves together, only held by an ungranted last stage
  assign advance         = ~valid_q[NrStages-1] | result_gnt_i;
  assign mul_req_ready_o = advance;
  assign accept          = mul_req_valid_i & advance;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= accept;
      for (int s = 1; s < NrStages; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  // Payload follows the valid bits, bubbles carry don't-care data
  always_ff @(posedge clk_i) begin
    if (advance) begin
      prod_q[0] <= product;
      op_q[0]   <= mul_op_i;
      id_q[0]   <= mul_id_i;
      addr_q[0] <= mul_addr_i;
      be_q[0]   <= mul_be_i;
      for (int s = 1; s < NrStages; s++) begin
        prod_q[s] <= prod_q[s-1];
        op_q[s]   <= op_q[s-1];
        id_q[s]   <= id_q[s-1];
        addr_q[s] <= addr_q[s-1];
        be_q[s]   <= be_q[s-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Last stage
  ////////////////////////////////////////////////////////////////////////////

  assign result_req_o  = valid_q[NrStages-1];
  assign result_id_o   = id_q[NrStages-1];
  assign result_addr_o = addr_q[NrStages-1];
  assign result_be_o   = be_q[NrStages-1];

  // Pick the requested half of the product
  assign result_wdata_o = (op_q[NrStages-1] == MUL_HU) ? prod_q[NrStages-1][ProdW-1:ElemW]
                                                       : prod_q[NrStages-1][ElemW-1:0];

endmodule : lane_mul

/* design/lane_op_pkg.sv */
package lane_op_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////////////////////////////////////////

  // Integer ALU operations
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4
  } alu_op_e;

  // Low half or unsigned high half of the product
  typedef enum logic [0:0] {
    MUL_LO = 1'b0,
    MUL_HU = 1'b1
  } mul_op_e;

  // Sub-word width for SIMD add and subtract
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  // Which unit produced a write-back
  typedef enum logic [0:0] {
    VFU_ALU = 1'b0,
    VFU_MUL = 1'b1
  } vfu_e;

endpackage : lane_op_pkg

/* design/lane_top.sv */
`timescale 1ns/1ps

module lane_top import lane_data_pkg::*; import lane_op_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // ALU request channel
  input  logic    alu_req_valid_i,
  output logic    alu_req_ready_o,
  input  alu_op_e alu_op_i,
  input  ew_e     alu_ew_i,
  input  elen_t   alu_a_i,
  input  elen_t   alu_b_i,
  input  strb_t   alu_be_i,
  input  vid_t    alu_id_i,
  input  waddr_t  alu_addr_i,
  // Multiplier request channel
  input  logic    mul_req_valid_i,
  output logic    mul_req_ready_o,
  input  mul_op_e mul_op_i,
  input  elen_t   mul_a_i,
  input  elen_t   mul_b_i,
  input  strb_t   mul_be_i,
  input  vid_t    mul_id_i,
  input  waddr_t  mul_addr_i,
  // Write-back port
  output logic    wb_valid_o,
  output vfu_e    wb_src_o,
  output vid_t    wb_id_o,
  output waddr_t  wb_addr_o,
  output elen_t   wb_data_o,
  output strb_t   wb_be_o,
  input  logic    wb_ready_i
);

  // ALU result to arbiter
  logic   alu_result_req;
  vid_t   alu_result_id;
  waddr_t alu_result_addr;
  elen_t  alu_result_wdata;
  strb_t  alu_result_be;
  logic   alu_result_gnt;

  // Multiplier result to arbiter
  logic   mul_result_req;
  vid_t   mul_result_id;
  waddr_t mul_result_addr;
  elen_t  mul_result_wdata;
  strb_t  mul_result_be;
  logic   mul_result_gnt;

  lane_alu i_lane_alu (
    .clk_i          (clk_i           ),
    .rst_ni         (rst_ni          ),
    .alu_req_valid_i(alu_req_valid_i ),
    .alu_req_ready_o(alu_req_ready_o ),
    .alu_op_i       (alu_op_i        ),
    .alu_ew_i       (alu_ew_i        ),
    .alu_a_i        (alu_a_i         ),
    .alu_b_i        (alu_b_i         ),
    .alu_be_i       (alu_be_i        ),
    .alu_id_i       (alu_id_i        ),
    .alu_addr_i     (alu_addr_i      ),
    .result_req_o   (alu_result_req  ),
    .result_id_o    (alu_result_id   ),
    .result_addr_o  (alu_result_addr ),
    .result_wdata_o (alu_result_wdata),
    .result_be_o    (alu_result_be   ),
    .result_gnt_i   (alu_result_gnt  )
  );

  lane_mul i_lane_mul (
    .clk_i          (clk_i           ),
    .rst_ni         (rst_ni          ),
    .mul_req_valid_i(mul_req_valid_i ),
    .mul_req_ready_o(mul_req_ready_o ),
    .mul_op_i       (mul_op_i        ),
    .mul_a_i        (mul_a_i         ),
    .mul_b_i        (mul_b_i         ),
    .mul_be_i       (mul_be_i        ),
    .mul_id_i       (mul_id_i        ),
    .mul_addr_i     (mul_addr_i      ),
    .result_req_o   (mul_result_req  ),
    .result_id_o    (mul_result_id   ),
    .result_addr_o  (mul_result_addr ),
    .result_wdata_o (mul_result_wdata),
    .result_be_o    (mul_result_be   ),
    .result_gnt_i   (mul_result_gnt  )
  );

  lane_wb_arbiter i_lane_wb_arbiter (
    .clk_i      (clk_i           ),
    .rst_ni     (rst_ni          ),
    .alu_req_i  (alu_result_req  ),
    .alu_id_i   (alu_result_id   ),
    .alu_addr_i (alu_result_addr ),
    .alu_wdata_i(alu_result_wdata),
    .alu_be_i   (alu_result_be   ),
    .alu_gnt_o  (alu_result_gnt  ),
    .mul_req_i  (mul_result_req  ),
    .mul_id_i   (mul_result_id   ),
    .mul_addr_i (mul_result_addr ),
    .mul_wdata_i(mul_result_wdata),
    .mul_be_i   (mul_result_be   ),
    .mul_gnt_o  (mul_result_gnt  ),
    .wb_valid_o (wb_valid_o      ),
    .wb_src_o   (wb_src_o        ),
    .wb_id_o    (wb_id_o         ),
    .wb_addr_o  (wb_addr_o       ),
    .wb_data_o  (wb_data_o       ),
    .wb_be_o    (wb_be_o         ),
    .wb_ready_i (wb_ready_i      )
  );

endmodule : lane_top

/* design/lane_wb_arbiter.sv */
`timescale 1ns/1ps

module lane_wb_arbiter import lane_data_pkg::*; import lane_op_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // ALU result
  input  logic   alu_req_i,
  input  vid_t   alu_id_i,
  input  waddr_t alu_addr_i,
  input  elen_t  alu_wdata_i,
  input  strb_t  alu_be_i,
  output logic   alu_gnt_o,
  // Multiplier result
  input  logic   mul_req_i,
  input  vid_t   mul_id_i,
  input  waddr_t mul_addr_i,
  input  elen_t  mul_wdata_i,
  input  strb_t  mul_be_i,
  output logic   mul_gnt_o,
  // Write-back port
  output logic   wb_valid_o,
  output vfu_e   wb_src_o,
  output vid_t   wb_id_o,
  output waddr_t wb_addr_o,
  output elen_t  wb_data_o,
  output strb_t  wb_be_o,
  input  logic   wb_ready_i
);

  logic   wb_valid_q;
  vfu_e   wb_src_q;
  vid_t   wb_id_q;
  waddr_t wb_addr_q;
  elen_t  wb_data_q;
  strb_t  wb_be_q;

  // Unit granted most recently
  vfu_e last_q;
  logic load;

  // Output stage can take a new entry
  assign load = ~wb_valid_q | wb_ready_i;

  // On contention the unit that did not win last time goes first
  assign alu_gnt_o = load & alu_req_i & (~mul_req_i | (last_q == VFU_MUL));
  assign mul_gnt_o = load & mul_req_i & (~alu_req_i | (last_q == VFU_ALU));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
      last_q     <= VFU_MUL;
    end else begin
      if (load) begin
        wb_valid_q <= alu_gnt_o | mul_gnt_o;
      end
      if (alu_gnt_o) begin
        last_q <= VFU_ALU;
      end else if (mul_gnt_o) begin
        last_q <= VFU_MUL;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_gnt_o) begin
      wb_src_q  <= VFU_ALU;
      wb_id_q   <= alu_id_i;
      wb_addr_q <= alu_addr_i;
      wb_data_q <= alu_wdata_i;
      wb_be_q   <= alu_be_i;
    end else if (mul_gnt_o) begin
      wb_src_q  <= VFU_MUL;
      wb_id_q   <= mul_id_i;
      wb_addr_q <= mul_addr_i;
      wb_data_q <= mul_wdata_i;
      wb_be_q   <= mul_be_i;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_src_o   = wb_src_q;
  assign wb_id_o    = wb_id_q;
  assign wb_addr_o  = wb_addr_q;
  assign wb_data_o  = wb_data_q;
  assign wb_be_o    = wb_be_q;

endmodule : lane_wb_arbiter

/* filelist.f */
+incdir+design
design/lane_data_pkg.sv
design/lane_op_pkg.sv
design/lane_alu.sv
design/lane_mul.sv
design/lane_wb_arbiter.sv
design/lane_top.sv
test/tb_lane.sv

/* run_sim.sh */
#!/bin/sh
# Build the lane testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_lane -o tb_lane
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_lane > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
  echo "No result message found in $LOG"
  exit 1
fi

exit 0

/* test/tb_lane.sv */
`timescale 1ns/1ps

module tb_lane import lane_data_pkg::*; import lane_op_pkg::*; ();

  localparam int TIMEOUT = 500;

  // Expected write-back of one accepted request
  typedef struct packed {
    vid_t   id;
    waddr_t addr;
    elen_t  data;
    strb_t  be;
  } exp_t;

  logic    clk_i = 1'b0;
  logic    rst_ni;
  logic    alu_req_valid_i, alu_req_ready_o;
  alu_op_e alu_op_i;
  ew_e     alu_ew_i;
  elen_t   alu_a_i, alu_b_i;
  strb_t   alu_be_i;
  vid_t    alu_id_i;
  waddr_t  alu_addr_i;
  logic    mul_req_valid_i, mul_req_ready_o;
  mul_op_e mul_op_i;
  elen_t   mul_a_i, mul_b_i;
  strb_t   mul_be_i;
  vid_t    mul_id_i;
  waddr_t  mul_addr_i;
  logic    wb_valid_o, wb_ready_i;
  vfu_e    wb_src_o;
  vid_t    wb_id_o;
  waddr_t  wb_addr_o;
  elen_t   wb_data_o;
  strb_t   wb_be_o;

  integer seed;
  int     mismatch_count, fail_count, alu_seen, mul_seen;
  logic   traffic_done;
  exp_t   alu_q[$];
  exp_t   mul_q[$];

  lane_top lane_top_i (.*);

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Each sub-word wraps on its own
  function automatic elen_t alu_model(alu_op_e op, ew_e ew, elen_t a, elen_t b);
    int    w;
    elen_t mask, ea, eb, er, res;
    w    = 8 << ew;
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    res  = '0;
    case (op)
      AND:     res = a & b;
      OR:      res = a | b;
      XOR:     res = a ^ b;
      ADD, SUB: begin
        for (int k = 0; k < $bits(elen_t) / w; k++) begin
          ea  = (a >> (k * w)) & mask;
          eb  = (b >> (k * w)) & mask;
          er  = (op == SUB) ? ea - eb : ea + eb;
          res = res | ((er & mask) << (k * w));
        end
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic elen_t mul_model(mul_op_e op, elen_t a, elen_t b);
    logic [127:0] p;
    p = {64'd0, a} * {64'd0, b};
    return (op == MUL_HU) ? p[127:64] : p[63:0];
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic elen_t rand_elem();
    return {rand_word(), rand_word()};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_elem(input string what, input elen_t got, input elen_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_strb(input string what, input strb_t got, input strb_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_vid(input string what, input vid_t got, input vid_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input waddr_t got, input waddr_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_src(input string what, input vfu_e got, input vfu_e exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////////////////////

  // Sampled on the rising edge, before the DUT registers update
  task automatic monitor_results();
    exp_t e, held;
    vfu_e held_src;
    logic held_valid;
    held_valid = 1'b0;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        if (alu_req_valid_i && alu_req_ready_o) begin
          e.id   = alu_id_i;
          e.addr = alu_addr_i;
          e.be   = alu_be_i;
          e.data = alu_model(alu_op_i, alu_ew_i, alu_a_i, alu_b_i);
          alu_q.push_back(e);
        end
        if (mul_req_valid_i && mul_req_ready_o) begin
          e.id   = mul_id_i;
          e.addr = mul_addr_i;
          e.be   = mul_be_i;
          e.data = mul_model(mul_op_i, mul_a_i, mul_b_i);
          mul_q.push_back(e);
        end
        // Write-back port must not move while stalled
        if (held_valid) begin
          check_flag("wb_valid_o in stall", wb_valid_o, 1'b1);
          check_src("wb_src_o in stall", wb_src_o, held_src);
          check_vid("wb_id_o in stall", wb_id_o, held.id);
          check_addr("wb_addr_o in stall", wb_addr_o, held.addr);
          check_elem("wb_data_o in stall", wb_data_o, held.data);
          check_strb("wb_be_o in stall", wb_be_o, held.be);
        end
        if (wb_valid_o && wb_ready_i) begin
          if ((wb_src_o == VFU_ALU && alu_q.size() == 0) ||
              (wb_src_o == VFU_MUL && mul_q.size() == 0)) begin
            fail_count++;
            $display("Write-back from %s arrived with no request pending", wb_src_o.name());
          end else begin
            if (wb_src_o == VFU_ALU) begin
              e = alu_q.pop_front();
              alu_seen++;
            end else begin
              e = mul_q.pop_front();
              mul_seen++;
            end
            check_vid("wb_id_o", wb_id_o, e.id);
            check_addr("wb_addr_o", wb_addr_o, e.addr);
            check_elem("wb_data_o", wb_data_o, e.data);
            check_strb("wb_be_o", wb_be_o, e.be);
          end
        end
        held_valid = wb_valid_o && !wb_ready_i;
        held_src   = wb_src_o;
        held.id    = wb_id_o;
        held.addr  = wb_addr_o;
        held.data  = wb_data_o;
        held.be    = wb_be_o;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers, all changes on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic alu_send(input alu_op_e op, input ew_e ew);
    int cnt;
    alu_op_i        = op;
    alu_ew_i        = ew;
    alu_a_i         = rand_elem();
    alu_b_i         = rand_elem();
    alu_be_i        = strb_t'(rand_word());
    alu_id_i        = vid_t'(rand_word());
    alu_addr_i      = waddr_t'(rand_word());
    alu_req_valid_i = 1'b1;
    cnt = 0;
    @(posedge clk_i);
    while (!alu_req_ready_o && cnt < TIMEOUT) begin
      cnt++;
      @(posedge clk_i);
    end
    if (!alu_req_ready_o) begin
      fail_count++;
      $display("Timeout: ALU request was never accepted");
    end
    @(negedge clk_i);
    alu_req_valid_i = 1'b0;
  endtask

  task automatic mul_send(input mul_op_e op);
    int cnt;
    mul_op_i        = op;
    mul_a_i         = rand_elem();
    mul_b_i         = rand_elem();
    mul_be_i        = strb_t'(rand_word());
    mul_id_i        = vid_t'(rand_word());
    mul_addr_i      = waddr_t'(rand_word());
    mul_req_valid_i = 1'b1;
    cnt = 0;
    @(posedge clk_i);
    while (!mul_req_ready_o && cnt < TIMEOUT) begin
      cnt++;
      @(posedge clk_i);
    end
    if (!mul_req_ready_o) begin
      fail_count++;
      $display("Timeout: multiplier request was never accepted");
    end
    @(negedge clk_i);
    mul_req_valid_i = 1'b0;
  endtask

  task automatic drive_alu(input int n, input int max_gap);
    logic [31:0] r;
    int unsigned gap;
    for (int i = 0; i < n; i++) begin
      r   = rand_word();
      gap = rand_word() % (max_gap + 1);
      repeat (gap) @(negedge clk_i);
      alu_send(alu_op_e'(3'(r % 32'd5)), ew_e'(r[9:8]));
    end
  endtask

  task automatic drive_mul(input int n, input int max_gap);
    logic [31:0] r;
    int unsigned gap;
    for (int i = 0; i < n; i++) begin
      r   = rand_word();
      gap = rand_word() % (max_gap + 1);
      repeat (gap) @(negedge clk_i);
      mul_send(mul_op_e'(r[0]));
    end
  endtask

  // Random back-pressure until both drivers are done
  task automatic toggle_ready();
    logic [31:0] r;
    int cnt;
    cnt = 0;
    while (!traffic_done && cnt < 40 * TIMEOUT) begin
      @(negedge clk_i);
      r = rand_word();
      wb_ready_i = (r[1:0] != 2'b00);
      cnt++;
    end
    if (!traffic_done) begin
      fail_count++;
      $display("Timeout: random traffic did not finish");
    end
    wb_ready_i = 1'b1;
  endtask

  task automatic wait_readies(input logic level);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    while (!(alu_req_ready_o === level && mul_req_ready_o === level) && cnt < TIMEOUT) begin
      cnt++;
      @(posedge clk_i);
    end
    if (!(alu_req_ready_o === level && mul_req_ready_o === level)) begin
      fail_count++;
      $display("Timeout: request readies did not both reach %b", level);
    end
    @(negedge clk_i);
  endtask

  // Queues only change on the rising edge
  task automatic wait_drain();
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while ((alu_q.size() != 0 || mul_q.size() != 0 || wb_valid_o) && cnt < TIMEOUT) begin
      cnt++;
      @(negedge clk_i);
    end
    if (alu_q.size() != 0 || mul_q.size() != 0) begin
      fail_count++;
      $display("Timeout: %0d ALU and %0d multiplier results never written back",
               alu_q.size(), mul_q.size());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed            = 32'hcbdb39d0;
    mismatch_count  = 0;
    fail_count      = 0;
    alu_seen        = 0;
    mul_seen        = 0;
    traffic_done    = 1'b0;
    rst_ni          = 1'b0;
    alu_req_valid_i = 1'b0;
    alu_op_i        = ADD;
    alu_ew_i        = EW64;
    alu_a_i         = '0;
    alu_b_i         = '0;
    alu_be_i        = '0;
    alu_id_i        = '0;
    alu_addr_i      = '0;
    mul_req_valid_i = 1'b0;
    mul_op_i        = MUL_LO;
    mul_a_i         = '0;
    mul_b_i         = '0;
    mul_be_i        = '0;
    mul_id_i        = '0;
    mul_addr_i      = '0;
    wb_ready_i      = 1'b1;
    fork
      monitor_results();
    join_none
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    @(posedge clk_i);
    check_flag("wb_valid_o after reset", wb_valid_o, 1'b0);
    check_flag("alu_req_ready_o after reset", alu_req_ready_o, 1'b1);
    check_flag("mul_req_ready_o after reset", mul_req_ready_o, 1'b1);
    @(negedge clk_i);

    // Every ALU opcode at every element width
    for (int o = 0; o < 5; o++) begin
      for (int w = 0; w < 4; w++) begin
        repeat (3) alu_send(alu_op_e'(3'(o)), ew_e'(2'(w)));
      end
    end
    wait_drain();

    // Back-to-back products, pipe fills up
    repeat (8) begin
      mul_send(MUL_LO);
      mul_send(MUL_HU);
    end
    wait_drain();

    // Both channels at once under random back-pressure
    fork
      begin
        fork
          drive_alu(60, 3);
          drive_mul(60, 3);
        join
        traffic_done = 1'b1;
      end
      toggle_ready();
    join
    wait_drain();

    // Long stall backs up into both request channels
    wb_ready_i = 1'b0;
    fork
      drive_alu(3, 0);
      drive_mul(6, 0);
      begin
        wait_readies(1'b0);
        repeat (10) @(negedge clk_i);
        @(posedge clk_i);
        check_flag("alu_req_ready_o in long stall", alu_req_ready_o, 1'b0);
        check_flag("mul_req_ready_o in long stall", mul_req_ready_o, 1'b0);
        @(negedge clk_i);
        wb_ready_i = 1'b1;
      end
    join
    wait_readies(1'b1);
    wait_drain();

    $display("Checked %0d ALU and %0d multiplier results: %0d mismatches, %0d other failures",
             alu_seen, mul_seen, mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_lane
